/* spc_bridge.f */
+incdir+design
design/spc_bridge_pkg.sv
design/pcx_request_decoder.sv
design/cpx_packet_builder.sv
design/bridge_fsm.sv
design/spc_bridge_top.sv
sim/spc_bridge_tb.sv

/* Bender.yml */
package:
  name: spc_bridge

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/spc_bridge_pkg.sv
      - design/pcx_request_decoder.sv
      - design/cpx_packet_builder.sv
      - design/bridge_fsm.sv
      - design/spc_bridge_top.sv
      - target: simulation
        files:
          - sim/spc_bridge_tb.sv

/* sim/spc_bridge_tb.sv */
`timescale 1ns/100ps
`include "spc_bridge_params.svh"

module spc_bridge_tb;
  import spc_bridge_pkg::*;

  localparam int NUM_REQ    = 40;
  localparam int SEED       = 90402;
  localparam int MAX_CYCLES = NUM_REQ * 20 + 200;   // Worst case about 12 cycles per request

  logic                      sys_clock_i;
  logic                      sys_reset_i;
  logic [`REGION_WIDTH-1:0]  spc_req_i;
  pcx_packet_t               spc_packetout_i;
  logic [`REGION_WIDTH-1:0]  spc_grant_o;
  logic                      spc_ready_o;
  cpx_packet_t               spc_packetin_o;
  logic                      spc_stallreq_o;
  logic                      wbm_ack_i;
  logic [`WB_DATA_WIDTH-1:0] wbm_data_i;
  logic                      wbm_cycle_o;
  logic                      wbm_strobe_o;
  logic                      wbm_we_o;
  logic [`WB_ADDR_WIDTH-1:0] wbm_addr_o;
  logic [`WB_DATA_WIDTH-1:0] wbm_data_o;
  logic [`WB_SEL_WIDTH-1:0]  wbm_sel_o;

  // Model of the request in flight
  logic [`REGION_WIDTH-1:0]  cur_region;
  pcx_packet_t               cur_pkt;
  logic [`WB_DATA_WIDTH-1:0] exp_rdata;             // Read data the slave returned
  cpx_packet_t               wakeup_exp;
  cpx_packet_t               exp_rsp;
  logic [`WB_ADDR_WIDTH-1:0] exp_addr;
  logic [`WB_SEL_WIDTH-1:0]  exp_sel;
  logic                      exp_we;
  logic                      req_accept;            // Request sampled while bridge idle
  int                        acks_seen   = 0;
  int                        ready_count = 0;
  int                        cycle_count = 0;
  int                        ack_wait    = 0;
  logic                      ack_armed   = 1'b0;

  spc_bridge_top uut (
    .sys_clock_i     (sys_clock_i),
    .sys_reset_i     (sys_reset_i),
    .spc_req_i       (spc_req_i),
    .spc_packetout_i (spc_packetout_i),
    .spc_grant_o     (spc_grant_o),
    .spc_ready_o     (spc_ready_o),
    .spc_packetin_o  (spc_packetin_o),
    .spc_stallreq_o  (spc_stallreq_o),
    .wbm_ack_i       (wbm_ack_i),
    .wbm_data_i      (wbm_data_i),
    .wbm_cycle_o     (wbm_cycle_o),
    .wbm_strobe_o    (wbm_strobe_o),
    .wbm_we_o        (wbm_we_o),
    .wbm_addr_o      (wbm_addr_o),
    .wbm_data_o      (wbm_data_o),
    .wbm_sel_o       (wbm_sel_o)
  );

  initial begin
    sys_clock_i = 1'b0;
    forever #2 sys_clock_i = ~sys_clock_i;          // 4 ns period
  end

  task automatic fail_value(input string name, input logic [255:0] exp_val,
                            input logic [255:0] act_val);
    $display("ERR %s: expected %0h, actual %0h", name, exp_val, act_val);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // Region on top, doubleword address below
  function automatic logic [63:0] expect_addr(logic [4:0] region, pcx_packet_t req);
    return {region, 19'h0, req.addr[39:3], 3'b000};
  endfunction

  function automatic logic [7:0] expect_sel(pcx_packet_t req);
    logic [7:0] sel;
    sel = 8'h00;
    if (req.rq_type == LOAD_RQ || req.rq_type == STORE_RQ) begin
      case (req.size)
        SZ_1B:   sel = 8'h01 << req.addr[2:0];
        SZ_2B:   sel = 8'h03 << (2 * req.addr[2:1]);
        SZ_4B:   sel = 8'h0f << (4 * req.addr[2]);
        SZ_8B:   sel = 8'hff;
        default: sel = 8'h00;
      endcase
    end
    return sel;
  endfunction

  function automatic cpx_packet_t expect_response(pcx_packet_t req, logic [4:0] region,
                                                  logic [63:0] rdata);
    cpx_packet_t rsp;
    rsp            = '0;
    rsp.valid      = 1'b1;
    rsp.rtn_type   = (req.rq_type == LOAD_RQ) ? LOAD_RET : ST_ACK;
    rsp.nc         = req.nc;
    rsp.thread     = req.thread;
    rsp.boot_fetch = (region == 5'b10000);
    rsp.data[127:64] = req.addr[3] ? 64'h0 : rdata;   // Even doubleword on top
    rsp.data[63:0]   = req.addr[3] ? rdata : 64'h0;
    return rsp;
  endfunction

  function automatic cpx_packet_t expect_wakeup();
    cpx_packet_t rsp;
    rsp          = '0;
    rsp.valid    = 1'b1;
    rsp.rtn_type = INT_RET;
    rsp.data     = {64'h0, 64'h10001};
    return rsp;
  endfunction

  assign exp_addr   = expect_addr(cur_region, cur_pkt);
  assign exp_sel    = expect_sel(cur_pkt);
  assign exp_we     = (cur_pkt.rq_type != LOAD_RQ);
  assign exp_rsp    = expect_response(cur_pkt, cur_region, exp_rdata);
  assign req_accept = (spc_req_i != '0) && !spc_stallreq_o;

  // Random request, held on the PCX bus until the next one
  task automatic issue_request();
    pcx_packet_t pkt;
    int unsigned kind;
    pkt            = '0;
    kind           = $urandom_range(9, 0);
    pkt.valid      = 1'b1;
    if (kind < 4) begin
      pkt.rq_type = LOAD_RQ;
    end else if (kind < 8) begin
      pkt.rq_type = STORE_RQ;
    end else begin
      pkt.rq_type = $urandom_range(31, 2);          // Some other request type
    end
    pkt.nc         = $urandom_range(1, 0);
    pkt.cpu_id     = $urandom_range(7, 0);
    pkt.thread     = $urandom_range(3, 0);
    pkt.size       = $urandom_range(4, 0);          // 4 is a 16-byte size, no lanes
    pkt.addr       = {$urandom, $urandom};
    pkt.data       = {$urandom, $urandom};
    @(negedge sys_clock_i);
    cur_region      = 5'b00001 << $urandom_range(4, 0);
    cur_pkt         = pkt;
    spc_req_i       = cur_region;
    spc_packetout_i = pkt;
    @(negedge sys_clock_i);
    spc_req_i = '0;                                 // Request seen at the last edge
    do @(negedge sys_clock_i); while (!spc_ready_o);
  endtask

  // Wishbone slave, ack after 0 to 3 wait cycles
  always @(negedge sys_clock_i) begin
    if (wbm_cycle_o && wbm_strobe_o && !wbm_ack_i) begin
      if (!ack_armed) begin
        ack_armed = 1'b1;
        ack_wait  = $urandom_range(3, 0);
      end
      if (ack_wait == 0) begin
        wbm_ack_i  = 1'b1;
        wbm_data_i = {$urandom, $urandom};
        exp_rdata  = wbm_data_i;
        ack_armed  = 1'b0;
        acks_seen++;
      end else begin
        ack_wait--;
      end
    end else begin
      wbm_ack_i = 1'b0;
    end
  end

  always @(negedge sys_clock_i) begin
    if (spc_ready_o) ready_count++;                 // One count per ready cycle
  end

  initial begin
    void'($urandom(SEED));
    sys_reset_i     = 1'b1;
    spc_req_i       = '0;
    spc_packetout_i = '0;
    wbm_ack_i       = 1'b0;
    wbm_data_i      = '0;
    cur_region      = '0;
    cur_pkt         = '0;
    exp_rdata       = '0;
    wakeup_exp      = expect_wakeup();
    repeat (3) @(negedge sys_clock_i);
    sys_reset_i = 1'b0;
    do @(negedge sys_clock_i); while (!spc_ready_o);  // Wakeup pulse first
    for (int i = 0; i < NUM_REQ; i++) begin
      issue_request();
    end
    repeat (4) @(negedge sys_clock_i);
    if (ready_count == NUM_REQ + 1 && acks_seen == NUM_REQ) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_value("ready pulse count", NUM_REQ + 1, ready_count);
    end
  end

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge sys_clock_i);
      cycle_count++;
    end
    fail_plain("Timeout, the bridge stopped answering requests");
  end

  // Wakeup packet right after reset
  wakeup_ready_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    $fell(sys_reset_i) |=> spc_ready_o)
    else fail_value("wakeup ready", 1, $sampled(spc_ready_o));
  wakeup_pkt_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    $fell(sys_reset_i) |=> (spc_packetin_o == wakeup_exp))
    else fail_value("wakeup packet", $sampled(wakeup_exp), $sampled(spc_packetin_o));

  // Grant timing
  grant_early_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    req_accept |=> (spc_grant_o == '0))
    else fail_value("grant before capture", 0, $sampled(spc_grant_o));
  grant_value_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    req_accept |-> ##2 (spc_grant_o == cur_region))
    else fail_value("grant value", $sampled(cur_region), $sampled(spc_grant_o));
  grant_pulse_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (spc_grant_o != '0) |=> (spc_grant_o == '0))
    else fail_value("grant width", 0, $sampled(spc_grant_o));

  // Stall from request until the response has gone out
  stall_set_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    req_accept |=> spc_stallreq_o)
    else fail_value("stall on request", 1, $sampled(spc_stallreq_o));
  stall_hold_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (spc_stallreq_o && !spc_ready_o) |=> spc_stallreq_o)
    else fail_plain("Stall dropped before the return packet was sent");

  // Bus fields during the strobe
  addr_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wbm_strobe_o |-> (wbm_addr_o == exp_addr))
    else fail_value("wishbone address", $sampled(exp_addr), $sampled(wbm_addr_o));
  sel_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wbm_strobe_o |-> (wbm_sel_o == exp_sel))
    else fail_value("byte select", $sampled(exp_sel), $sampled(wbm_sel_o));
  we_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wbm_strobe_o |-> (wbm_we_o == exp_we))
    else fail_value("write enable", $sampled(exp_we), $sampled(wbm_we_o));
  store_data_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (wbm_strobe_o && cur_pkt.rq_type == STORE_RQ) |-> (wbm_data_o == cur_pkt.data))
    else fail_value("store data", $sampled(cur_pkt.data), $sampled(wbm_data_o));
  bus_clear_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    $fell(wbm_cycle_o) |-> (wbm_addr_o == '0 && wbm_data_o == '0 && wbm_sel_o == '0))
    else fail_plain("Wishbone address, data or select not cleared after ack");

  // One response per ack
  ready_after_ack_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    $fell(wbm_cycle_o) |=> spc_ready_o)
    else fail_value("ready after ack", 1, $sampled(spc_ready_o));
  ready_pulse_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    spc_ready_o |=> !spc_ready_o)
    else fail_value("ready width", 0, $sampled(spc_ready_o));
  response_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (spc_ready_o && acks_seen != 0) |-> (spc_packetin_o == exp_rsp))
    else fail_value("response packet", $sampled(exp_rsp), $sampled(spc_packetin_o));

endmodule

/* design/spc_bridge_top.sv */
`timescale 1ns/100ps
`include "spc_bridge_params.svh"

module spc_bridge_top (
  input  logic                        sys_clock_i,
  input  logic                        sys_reset_i,
  // PCX side
  input  logic [`REGION_WIDTH-1:0]    spc_req_i,
  input  spc_bridge_pkg::pcx_packet_t spc_packetout_i,
  // CPX side
  output logic [`REGION_WIDTH-1:0]    spc_grant_o,
  output logic                        spc_ready_o,
  output spc_bridge_pkg::cpx_packet_t spc_packetin_o,  // Valid only with ready
  output logic                        spc_stallreq_o,
  // Wishbone master
  input  logic                        wbm_ack_i,
  input  logic [`WB_DATA_WIDTH-1:0]   wbm_data_i,
  output logic                        wbm_cycle_o,
  output logic                        wbm_strobe_o,
  output logic                        wbm_we_o,
  output logic [`WB_ADDR_WIDTH-1:0]   wbm_addr_o,
  output logic [`WB_DATA_WIDTH-1:0]   wbm_data_o,
  output logic [`WB_SEL_WIDTH-1:0]    wbm_sel_o
);
  import spc_bridge_pkg::*;

  // Packet layouts must match the crossbar widths
  if ($bits(pcx_packet_t) != `PCX_WIDTH) begin : g_pcx_width_check
    $error("pcx_packet_t width differs from PCX_WIDTH");
  end
  if ($bits(cpx_packet_t) != `CPX_WIDTH) begin : g_cpx_width_check
    $error("cpx_packet_t width differs from CPX_WIDTH");
  end

  logic                     latch_region;
  logic                     latch_packet;
  logic                     wb_issue;
  logic                     wb_done;
  logic [`REGION_WIDTH-1:0] region;
  pcx_packet_t              packet;
  wb_req_t                  wb_req;
  cpx_packet_t              rtn_packet;

  bridge_fsm u_fsm (
    .sys_clock_i    (sys_clock_i),
    .sys_reset_i    (sys_reset_i),
    .spc_req_i      (spc_req_i),
    .region_i       (region),
    .wbm_ack_i      (wbm_ack_i),
    .latch_region_o (latch_region),
    .latch_packet_o (latch_packet),
    .wb_issue_o     (wb_issue),
    .wb_done_o      (wb_done),
    .spc_grant_o    (spc_grant_o),
    .spc_stallreq_o (spc_stallreq_o),
    .spc_ready_o    (spc_ready_o),
    .wbm_cycle_o    (wbm_cycle_o),
    .wbm_strobe_o   (wbm_strobe_o)
  );

  pcx_request_decoder u_decoder (
    .sys_clock_i     (sys_clock_i),
    .sys_reset_i     (sys_reset_i),
    .latch_region_i  (latch_region),
    .latch_packet_i  (latch_packet),
    .wb_issue_i      (wb_issue),
    .wb_done_i       (wb_done),
    .spc_req_i       (spc_req_i),
    .spc_packetout_i (spc_packetout_i),
    .region_o        (region),
    .packet_o        (packet),
    .wb_req_o        (wb_req)
  );

  cpx_packet_builder u_builder (
    .sys_clock_i  (sys_clock_i),
    .sys_reset_i  (sys_reset_i),
    .wb_done_i    (wb_done),
    .packet_i     (packet),
    .region_i     (region),
    .wbm_data_i   (wbm_data_i),
    .rtn_packet_o (rtn_packet)
  );

  assign spc_packetin_o = rtn_packet;

  // Bus fields from the decoder register
  assign wbm_we_o   = wb_req.we;
  assign wbm_addr_o = wb_req.addr;
  assign wbm_data_o = wb_req.data;
  assign wbm_sel_o  = wb_req.sel;

endmodule

/* design/bridge_fsm.sv */
`timescale 1ns/100ps
`include "spc_bridge_params.svh"

module bridge_fsm (
  input  logic                     sys_clock_i,
  input  logic                     sys_reset_i,
  input  logic [`REGION_WIDTH-1:0] spc_req_i,       // One-hot request from core
  input  logic [`REGION_WIDTH-1:0] region_i,        // Latched region
  input  logic                     wbm_ack_i,
  output logic                     latch_region_o,
  output logic                     latch_packet_o,
  output logic                     wb_issue_o,
  output logic                     wb_done_o,
  output logic [`REGION_WIDTH-1:0] spc_grant_o,
  output logic                     spc_stallreq_o,
  output logic                     spc_ready_o,
  output logic                     wbm_cycle_o,
  output logic                     wbm_strobe_o
);
  import spc_bridge_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          req_any;

  assign req_any = |spc_req_i;

  // Strobes for the decoder and builder
  assign latch_region_o = (state_q == IDLE) && req_any;    // Requests ignored elsewhere
  assign latch_packet_o = (state_q == REQUEST_LATCHED);
  assign wb_issue_o     = (state_q == PACKET_LATCHED);
  assign wb_done_o      = (state_q == WAIT_ACK) && wbm_ack_i;

  // One request in flight, strictly serialized
  always_comb begin
    state_d = state_q;
    case (state_q)
      WAKEUP: begin
        state_d = IDLE;
      end
      IDLE: begin
        if (req_any) begin
          state_d = REQUEST_LATCHED;
        end
      end
      REQUEST_LATCHED: begin
        state_d = PACKET_LATCHED;
      end
      PACKET_LATCHED: begin
        state_d = WAIT_ACK;
      end
      WAIT_ACK: begin
        if (wbm_ack_i) begin           // Slave may stretch this
          state_d = PACKET_READY;
        end
      end
      PACKET_READY: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q        <= WAKEUP;
      spc_grant_o    <= '0;
      spc_stallreq_o <= 1'b0;
      spc_ready_o    <= 1'b0;
      wbm_cycle_o    <= 1'b0;
      wbm_strobe_o   <= 1'b0;
    end else begin
      state_q     <= state_d;
      spc_grant_o <= latch_packet_o ? region_i : '0;                // Single-cycle grant
      spc_ready_o <= (state_q == WAKEUP) || (state_q == PACKET_READY);
      if (state_q == IDLE) begin
        spc_stallreq_o <= req_any;     // Held until an idle cycle without request
      end
      // Single-beat access, cycle and strobe together
      if (wb_issue_o) begin
        wbm_cycle_o  <= 1'b1;
        wbm_strobe_o <= 1'b1;
      end else if (wb_done_o) begin
        wbm_cycle_o  <= 1'b0;
        wbm_strobe_o <= 1'b0;
      end
    end
  end

  // No strobe outside a bus cycle or while not waiting for ack
  stb_in_cyc_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wbm_strobe_o |-> (wbm_cycle_o && state_q == WAIT_ACK));

  // Response goes out only after the bus is released
  ready_no_stb_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    !(spc_ready_o && wbm_strobe_o));

  // grant follows the packet capture cycle only
  grant_window_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (spc_grant_o != '0) |-> (state_q == PACKET_LATCHED));

endmodule

/* design/cpx_packet_builder.sv */
`timescale 1ns/100ps
`include "spc_bridge_params.svh"

module cpx_packet_builder (
  input  logic                        sys_clock_i,
  input  logic                        sys_reset_i,
  input  logic                        wb_done_i,      // Ack edge of the access
  input  spc_bridge_pkg::pcx_packet_t packet_i,       // Latched request
  input  logic [`REGION_WIDTH-1:0]    region_i,
  input  logic [`WB_DATA_WIDTH-1:0]   wbm_data_i,
  output spc_bridge_pkg::cpx_packet_t rtn_packet_o
);
  import spc_bridge_pkg::*;

  // Interrupt packet that starts the core
  localparam cpx_packet_t WAKEUP_PKT = '{
    valid:    1'b1,
    rtn_type: INT_RET,
    data:     {{`WB_DATA_WIDTH{1'b0}}, `WAKEUP_DATA},
    default:  '0
  };

  cpx_packet_t resp_pkt;
  cpx_packet_t rtn_q;

  // Response for the access just acknowledged
  always_comb begin
    resp_pkt            = '0;          // Miss, error, way, atomic and pfl stay clear
    resp_pkt.valid      = 1'b1;
    resp_pkt.rtn_type   = (packet_i.rq_type == LOAD_RQ) ? LOAD_RET : ST_ACK;
    resp_pkt.nc         = packet_i.nc;
    resp_pkt.thread     = packet_i.thread;
    resp_pkt.boot_fetch = (region_i == `IO_REGION);    // Fetch from boot block
    // Even doubleword goes in the upper half
    if (packet_i.addr[3]) begin
      resp_pkt.data = {{`WB_DATA_WIDTH{1'b0}}, wbm_data_i};
    end else begin
      resp_pkt.data = {wbm_data_i, {`WB_DATA_WIDTH{1'b0}}};
    end
  end

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      rtn_q <= WAKEUP_PKT;             // First thing the core sees
    end else if (wb_done_i) begin
      rtn_q <= resp_pkt;               // Read data captured at ack
    end
  end

  assign rtn_packet_o = rtn_q;

endmodule

/* design/pcx_request_decoder.sv */
`timescale 1ns/100ps
`include "spc_bridge_params.svh"

module pcx_request_decoder (
  input  logic                        sys_clock_i,
  input  logic                        sys_reset_i,
  input  logic                        latch_region_i,   // Request seen in IDLE
  input  logic                        latch_packet_i,   // Packet valid on the PCX bus
  input  logic                        wb_issue_i,       // Wishbone access starts
  input  logic                        wb_done_i,        // Access acknowledged
  input  logic [`REGION_WIDTH-1:0]    spc_req_i,
  input  spc_bridge_pkg::pcx_packet_t spc_packetout_i,
  output logic [`REGION_WIDTH-1:0]    region_o,
  output spc_bridge_pkg::pcx_packet_t packet_o,
  output spc_bridge_pkg::wb_req_t     wb_req_o
);
  import spc_bridge_pkg::*;

  localparam int PCX_AW    = 40;                                   // Request address bits
  localparam int PAD_WIDTH = `WB_ADDR_WIDTH - `REGION_WIDTH - PCX_AW;

  // Lane masks before shifting into place
  localparam logic [`WB_SEL_WIDTH-1:0] SEL_1B = 'h01;
  localparam logic [`WB_SEL_WIDTH-1:0] SEL_2B = 'h03;
  localparam logic [`WB_SEL_WIDTH-1:0] SEL_4B = 'h0f;

  logic [`REGION_WIDTH-1:0] region_q;
  pcx_packet_t              packet_q;
  logic [`WB_SEL_WIDTH-1:0] size_sel;
  logic                     is_ldst;     // Load or store, gets real lanes
  wb_req_t                  wb_req_d;
  wb_req_t                  wb_req_q;

  // Region first, packet one cycle later
  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      region_q <= '0;
    end else if (latch_region_i) begin
      region_q <= spc_req_i;
    end
  end

  always_ff @(posedge sys_clock_i) begin
    if (latch_packet_i) begin
      packet_q <= spc_packetout_i;      // Payload only
    end
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (packet_q.size)
      SZ_1B:   size_sel = SEL_1B << packet_q.addr[2:0];
      SZ_2B:   size_sel = SEL_2B << {packet_q.addr[2:1], 1'b0};
      SZ_4B:   size_sel = SEL_4B << {packet_q.addr[2], 2'b00};
      SZ_8B:   size_sel = '1;
      default: size_sel = '0;          // 16-byte and reserved sizes
    endcase
  end

  assign is_ldst = (packet_q.rq_type == LOAD_RQ) || (packet_q.rq_type == STORE_RQ);

  always_comb begin
    wb_req_d.we   = (packet_q.rq_type != LOAD_RQ);        // Everything but loads writes
    // Region on top, doubleword aligned address below
    wb_req_d.addr = {region_q, {PAD_WIDTH{1'b0}}, packet_q.addr[PCX_AW-1:3], 3'b000};
    wb_req_d.data = packet_q.data;
    wb_req_d.sel  = is_ldst ? size_sel : '0;              // Other types touch no lanes
  end

  // Bus fields held for the whole access, cleared at ack
  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      wb_req_q <= '0;
    end else if (wb_issue_i) begin
      wb_req_q <= wb_req_d;
    end else if (wb_done_i) begin
      wb_req_q <= '0;
    end
  end

  assign region_o = region_q;
  assign packet_o = packet_q;
  assign wb_req_o = wb_req_q;

  // Core must target exactly one region
  region_onehot_a: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    latch_region_i |=> $onehot(region_q));

endmodule

/* design/spc_bridge_pkg.sv */
`include "spc_bridge_params.svh"

package spc_bridge_pkg;

  // PCX request types, only these two get a real access
  typedef enum logic [4:0] {
    LOAD_RQ  = 5'b00000,
    STORE_RQ = 5'b00001
  } pcx_rq_e;

  // CPX return types
  typedef enum logic [3:0] {
    LOAD_RET = 4'b0000,
    ST_ACK   = 4'b0100,
    INT_RET  = 4'b0111      // Also used for the wakeup packet
  } cpx_rtn_e;

  // Access size field of a request
  typedef enum logic [2:0] {
    SZ_1B = 3'b000,
    SZ_2B = 3'b001,
    SZ_4B = 3'b010,
    SZ_8B = 3'b011
  } pcx_size_e;

  // Bridge sequencer states
  typedef enum logic [2:0] {
    WAKEUP,
    IDLE,
    REQUEST_LATCHED,
    PACKET_LATCHED,
    WAIT_ACK,
    PACKET_READY
  } bridge_state_e;

  // Request packet from the core, MSB first
  typedef struct packed {
    logic                      valid;
    logic [4:0]                rq_type;     // Compared against pcx_rq_e
    logic                      nc;          // Non-cacheable
    logic [2:0]                cpu_id;
    logic [1:0]                thread;
    logic                      invalidate;
    logic [1:0]                way;         // Replaced L1 way
    logic [2:0]                size;        // Compared against pcx_size_e
    logic [1:0]                reserved;
    logic [39:0]               addr;        // Physical address
    logic [`WB_DATA_WIDTH-1:0] data;        // Store data
  } pcx_packet_t;

  // Return packet to the core, MSB first
  typedef struct packed {
    logic                        valid;
    logic [3:0]                  rtn_type;  // Holds a cpx_rtn_e value
    logic                        miss;      // L2 miss
    logic [1:0]                  error;
    logic                        nc;
    logic [1:0]                  thread;
    logic                        way_valid;
    logic [1:0]                  way;
    logic                        boot_fetch;
    logic                        atomic;
    logic                        pfl;
    logic [2*`WB_DATA_WIDTH-1:0] data;      // Two doublewords
  } cpx_packet_t;

  // Fields of one Wishbone access
  typedef struct packed {
    logic                      we;
    logic [`WB_ADDR_WIDTH-1:0] addr;
    logic [`WB_DATA_WIDTH-1:0] data;
    logic [`WB_SEL_WIDTH-1:0]  sel;
  } wb_req_t;

endpackage

/* design/spc_bridge_params.svh */
`ifndef SPC_BRIDGE_PARAMS_SVH
`define SPC_BRIDGE_PARAMS_SVH

// Crossbar packet widths
`define PCX_WIDTH     124        // Core to bridge request
`define CPX_WIDTH     145        // Bridge to core return

// Wishbone master port
`define WB_ADDR_WIDTH 64
`define WB_DATA_WIDTH 64
`define WB_SEL_WIDTH  8          // One select per byte lane

// Target regions, one-hot from the core
`define REGION_WIDTH  5
`define IO_REGION     5'b10000   // I/O block and boot ROM

// Payload of the interrupt packet that wakes the core
`define WAKEUP_DATA   64'h10001

`endif
